// File: Makefile
TOP := tb_digital_macro

all: run

obj_dir/V$(TOP): tb.f *.sv
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module $(TOP) -o V$(TOP)

build: obj_dir/V$(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Everything OK$$" sim.log

lint:
	verilator --lint-only -Wall --timing -f tb.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// File: digital_macro.sv
/* Digital energy engine top */

`timescale 1ns/1ps
`default_nettype none

module digital_macro
    import ising_pkg::*;
(
    input  wire logic                      clk_i,
    input  wire logic                      arst_n_i,
    input  wire logic                      flush_i,
    input  wire logic                      spin_valid_i,
    input  wire spin_t                     spin_i,
    output logic                           spin_ready_o,
    output logic                           weight_ren_o,
    output logic [J_ADDR_BIT-1:0]          weight_raddr_o,
    input  wire j_word_t                   weight_rdata_i,
    input  wire logic [NUM_SPIN*BITH-1:0]  hbias_i,
    input  wire logic [SCALING_BIT-1:0]    hscaling_i,
    output logic                           energy_valid_o,
    output energy_result_t                 energy_o,
    input  wire logic                      energy_ready_i,
    output energy_t                        best_energy_o,
    output spin_t                          best_spin_o,
    output logic                           best_update_o
);

    logic    word_valid, word_ready;
    j_word_t word_data;
    logic    j_ready, h_ready;
    logic    spin_accept;
    logic    j_valid, h_valid, take;
    energy_t j_energy, h_energy;
    spin_t   spin_q;

    // both units must take the spin on the same edge
    assign spin_ready_o = j_ready && h_ready;
    assign spin_accept  = spin_valid_i && spin_ready_o;

    // held until the tracker takes the partial energies
    always_ff @(posedge clk_i) begin
        if (spin_accept) begin
            spin_q <= spin_i;
        end
    end

    weight_fetch u_fetch (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush_i),
        .weight_ren_o   (weight_ren_o),
        .weight_raddr_o (weight_raddr_o),
        .weight_rdata_i (weight_rdata_i),
        .word_valid_o   (word_valid),
        .word_data_o    (word_data),
        .word_ready_i   (word_ready)
    );

    j_energy_accum u_j_accum (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .spin_valid_i (spin_accept),
        .spin_i       (spin_i),
        .spin_ready_o (j_ready),
        .word_valid_i (word_valid),
        .word_data_i  (word_data),
        .word_ready_o (word_ready),
        .take_i       (take),
        .j_valid_o    (j_valid),
        .j_energy_o   (j_energy)
    );

    h_energy_calc u_h_calc (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .flush_i      (flush_i),
        .spin_valid_i (spin_accept),
        .spin_i       (spin_i),
        .spin_ready_o (h_ready),
        .hbias_i      (hbias_i),
        .hscaling_i   (hscaling_i),
        .take_i       (take),
        .h_valid_o    (h_valid),
        .h_energy_o   (h_energy)
    );

    energy_tracker u_tracker (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush_i),
        .j_valid_i      (j_valid),
        .j_energy_i     (j_energy),
        .h_valid_i      (h_valid),
        .h_energy_i     (h_energy),
        .spin_i         (spin_q),
        .take_o         (take),
        .energy_valid_o (energy_valid_o),
        .energy_o       (energy_o),
        .energy_ready_i (energy_ready_i),
        .best_energy_o  (best_energy_o),
        .best_spin_o    (best_spin_o),
        .best_update_o  (best_update_o)
    );

endmodule

`default_nettype wire

// File: energy_tracker.sv
/* Total energy and best entry tracker */

`timescale 1ns/1ps
`default_nettype none

module energy_tracker
    import ising_pkg::*;
(
    input  wire logic    clk_i,
    input  wire logic    arst_n_i,
    input  wire logic    flush_i,
    input  wire logic    j_valid_i,
    input  wire energy_t j_energy_i,
    input  wire logic    h_valid_i,
    input  wire energy_t h_energy_i,
    input  wire spin_t   spin_i,
    output logic         take_o,
    output logic         energy_valid_o,
    output energy_result_t energy_o,
    input  wire logic    energy_ready_i,
    output energy_t      best_energy_o,
    output spin_t        best_spin_o,
    output logic         best_update_o
);

    energy_result_t out_q;
    logic           out_valid_q;
    logic           best_valid_q;
    logic           update_q;
    energy_t        best_energy_q;
    spin_t          best_spin_q;
    logic           out_xfer;
    logic           new_best;

    assign out_xfer = out_valid_q && energy_ready_i;
    // output slot free now or freed by this cycle's transfer
    assign take_o   = j_valid_i && h_valid_i && !flush_i && (!out_valid_q || energy_ready_i);
    assign new_best = out_xfer && (!best_valid_q || (out_q.energy < best_energy_q));

    assign energy_valid_o = out_valid_q;
    assign energy_o       = out_q;
    assign best_energy_o  = best_energy_q;
    assign best_spin_o    = best_spin_q;
    assign best_update_o  = update_q;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            out_valid_q  <= 1'b0;
            best_valid_q <= 1'b0;
            update_q     <= 1'b0;
        end else if (flush_i) begin
            out_valid_q  <= 1'b0;
            best_valid_q <= 1'b0;
            update_q     <= 1'b0;
        end else begin
            update_q <= new_best;
            if (new_best) begin
                best_valid_q <= 1'b1;
            end
            if (take_o) begin
                out_valid_q <= 1'b1;
            end else if (out_xfer) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (take_o) begin
            out_q.energy <= j_energy_i + h_energy_i;
            out_q.spin   <= spin_i;
        end
        if (new_best && !flush_i) begin
            best_energy_q <= out_q.energy;
            best_spin_q   <= out_q.spin;
        end
    end

    a_out_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i || flush_i)
        (energy_valid_o && !energy_ready_i) |=> (energy_valid_o && $stable(energy_o)));

endmodule

`default_nettype wire

// File: h_energy_calc.sv
/* Scaled bias energy */

`timescale 1ns/1ps
`default_nettype none

module h_energy_calc
    import ising_pkg::*;
(
    input  wire logic                      clk_i,
    input  wire logic                      arst_n_i,
    input  wire logic                      flush_i,
    input  wire logic                      spin_valid_i,
    input  wire spin_t                     spin_i,
    output logic                           spin_ready_o,
    input  wire logic [NUM_SPIN*BITH-1:0]  hbias_i,
    input  wire logic [SCALING_BIT-1:0]    hscaling_i,
    input  wire logic                      take_i,
    output logic                           h_valid_o,
    output energy_t                        h_energy_o
);

    unit_state_e            state_q;
    logic [J_ADDR_BIT-1:0]  slice_q;
    logic                   alive_q;
    spin_t                  spin_q;
    energy_t                acc_q;
    energy_t                slice_sum;
    energy_t                scale;

    assign spin_ready_o = alive_q && (state_q == IDLE);
    assign h_valid_o    = (state_q == DONE);
    assign h_energy_o   = acc_q;
    assign scale        = energy_t'({1'b0, hscaling_i});

    // signed biases of the current slice, sign taken from the spin
    always_comb begin : slice_add
        energy_t bias;
        int      idx;
        slice_sum = '0;
        for (int p = 0; p < PARALLELISM; p++) begin
            idx       = int'(slice_q) * PARALLELISM + p;
            bias      = energy_t'($signed(hbias_i[idx*BITH +: BITH]));
            slice_sum = spin_q[idx] ? slice_sum + bias : slice_sum - bias;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            alive_q <= 1'b0;
            state_q <= IDLE;
            slice_q <= '0;
        end else begin
            alive_q <= 1'b1;
            if (flush_i) begin
                state_q <= IDLE;
                slice_q <= '0;
            end else begin
                case (state_q)
                    IDLE: begin
                        if (spin_valid_i && spin_ready_o) begin
                            state_q <= RUN;
                            slice_q <= '0;
                        end
                    end
                    RUN: begin
                        slice_q <= slice_q + 1'b1;
                        if (slice_q == J_ADDR_BIT'(J_ROWS - 1)) begin
                            state_q <= DONE;
                        end
                    end
                    DONE: begin
                        if (take_i) begin
                            state_q <= IDLE;
                        end
                    end
                    default: state_q <= IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (spin_valid_i && spin_ready_o) begin
            spin_q <= spin_i;
            acc_q  <= '0;
        end else if (state_q == RUN) begin
            // last slice folds in the scaling
            if (slice_q == J_ADDR_BIT'(J_ROWS - 1)) begin
                acc_q <= (acc_q + slice_sum) * scale;
            end else begin
                acc_q <= acc_q + slice_sum;
            end
        end
    end

endmodule

`default_nettype wire

// File: ising_pkg.sv
/* Ising energy engine shared definitions */

`default_nettype none

package ising_pkg;

    // problem size
    localparam int NUM_SPIN    = 16;
    localparam int BITJ        = 4;
    localparam int BITH        = 4;
    localparam int SCALING_BIT = 4;
    localparam int PARALLELISM = 4;
    localparam int ENERGY_BIT  = 32;

    // weight memory geometry
    localparam int J_ROWS     = NUM_SPIN / PARALLELISM;
    localparam int J_ADDR_BIT = 2;
    localparam int J_ROW_BIT  = NUM_SPIN * BITJ;
    localparam int J_WORD_BIT = J_ROW_BIT * PARALLELISM;

    // prefetch buffer
    localparam int FETCH_DEPTH   = 2;
    localparam int FETCH_PTR_BIT = $clog2(FETCH_DEPTH);
    localparam int FETCH_CNT_BIT = $clog2(FETCH_DEPTH + 1);

    // bit i set means spin i is +1
    typedef logic [NUM_SPIN-1:0] spin_t;

    // row (addr * PARALLELISM + p) at slot p, J(i,j) at bit j * BITJ of its row
    typedef logic [J_WORD_BIT-1:0] j_word_t;

    typedef logic signed [ENERGY_BIT-1:0] energy_t;

    typedef struct packed {
        energy_t energy;
        spin_t   spin;
    } energy_result_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } unit_state_e;

endpackage

`default_nettype wire

// File: j_energy_accum.sv
/* Coupling energy accumulator */

`timescale 1ns/1ps
`default_nettype none

module j_energy_accum
    import ising_pkg::*;
(
    input  wire logic    clk_i,
    input  wire logic    arst_n_i,
    input  wire logic    flush_i,
    input  wire logic    spin_valid_i,
    input  wire spin_t   spin_i,
    output logic         spin_ready_o,
    input  wire logic    word_valid_i,
    input  wire j_word_t word_data_i,
    output logic         word_ready_o,
    input  wire logic    take_i,
    output logic         j_valid_o,
    output energy_t      j_energy_o
);

    unit_state_e            state_q;
    logic [J_ADDR_BIT-1:0]  row_cnt_q;
    logic                   alive_q;
    spin_t                  spin_q;
    energy_t                acc_q;
    energy_t                word_sum;
    logic                   word_hsk;

    assign spin_ready_o = alive_q && (state_q == IDLE);
    assign word_ready_o = (state_q == RUN);
    assign word_hsk     = word_valid_i && word_ready_o;
    assign j_valid_o    = (state_q == DONE);
    assign j_energy_o   = acc_q;

    // s_i * sum_j J(i,j) * s_j over the rows of one word
    always_comb begin : word_contrib
        energy_t row_dot;
        energy_t weight;
        int      row;
        word_sum = '0;
        for (int p = 0; p < PARALLELISM; p++) begin
            row_dot = '0;
            row     = int'(row_cnt_q) * PARALLELISM + p;
            for (int j = 0; j < NUM_SPIN; j++) begin
                weight  = energy_t'($signed(word_data_i[p*J_ROW_BIT + j*BITJ +: BITJ]));
                row_dot = spin_q[j] ? row_dot + weight : row_dot - weight;
            end
            word_sum = spin_q[row] ? word_sum + row_dot : word_sum - row_dot;
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            alive_q   <= 1'b0;
            state_q   <= IDLE;
            row_cnt_q <= '0;
        end else begin
            alive_q <= 1'b1;
            if (flush_i) begin
                state_q   <= IDLE;
                row_cnt_q <= '0;
            end else begin
                case (state_q)
                    IDLE: begin
                        if (spin_valid_i && spin_ready_o) begin
                            state_q   <= RUN;
                            row_cnt_q <= '0;
                        end
                    end
                    RUN: begin
                        if (word_hsk) begin
                            row_cnt_q <= row_cnt_q + 1'b1;
                            if (row_cnt_q == J_ADDR_BIT'(J_ROWS - 1)) begin
                                state_q <= DONE;
                            end
                        end
                    end
                    DONE: begin
                        if (take_i) begin
                            state_q <= IDLE;
                        end
                    end
                    default: state_q <= IDLE;
                endcase
            end
        end
    end

    // payload
    always_ff @(posedge clk_i) begin
        if (spin_valid_i && spin_ready_o) begin
            spin_q <= spin_i;
            acc_q  <= '0;
        end else if (word_hsk) begin
            acc_q <= acc_q + word_sum;
        end
    end

    // j_valid rises only on the edge after a word handshake
    a_done_after_word: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $rose(j_valid_o) |-> $past(word_hsk));

endmodule

`default_nettype wire

// File: tb.f
ising_pkg.sv
weight_fetch.sv
j_energy_accum.sv
h_energy_calc.sv
energy_tracker.sv
digital_macro.sv
tb_digital_macro.sv

// File: tb_digital_macro.sv
/* Energy engine random testbench */

`timescale 1ns/1ps
`default_nettype none

module tb_digital_macro
    import ising_pkg::*;
();

    localparam int NUM_SPINS_TOTAL = 200;
    localparam int FLUSH_AT        = 100;
    localparam int RUN_LIMIT       = 20000;
    localparam int RESULT_LIMIT    = 200;

    logic                      clk_i;
    logic                      arst_n_i;
    logic                      flush_i;
    logic                      spin_valid_i;
    spin_t                     spin_i;
    logic                      spin_ready_o;
    logic                      weight_ren_o;
    logic [J_ADDR_BIT-1:0]     weight_raddr_o;
    j_word_t                   weight_rdata_i;
    logic [NUM_SPIN*BITH-1:0]  hbias_i;
    logic [SCALING_BIT-1:0]    hscaling_i;
    logic                      energy_valid_o;
    energy_result_t            energy_o;
    logic                      energy_ready_i;
    energy_t                   best_energy_o;
    spin_t                     best_spin_o;
    logic                      best_update_o;

    // weight memory model
    j_word_t                   mem_q [J_ROWS];
    logic                      read_pend;
    logic [J_ADDR_BIT-1:0]     read_addr;

    // reference model state
    logic [31:0]               rng_q;
    energy_result_t            expect_q [$];
    logic                      best_valid;
    energy_t                   best_e;
    spin_t                     best_s;
    logic                      expect_update;
    logic                      hold_prev;
    energy_result_t            prev_out;
    int                        accepted;
    int                        cycles;
    int                        idle_cycles;
    logic                      flushed;

    digital_macro u_dut (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .flush_i        (flush_i),
        .spin_valid_i   (spin_valid_i),
        .spin_i         (spin_i),
        .spin_ready_o   (spin_ready_o),
        .weight_ren_o   (weight_ren_o),
        .weight_raddr_o (weight_raddr_o),
        .weight_rdata_i (weight_rdata_i),
        .hbias_i        (hbias_i),
        .hscaling_i     (hscaling_i),
        .energy_valid_o (energy_valid_o),
        .energy_o       (energy_o),
        .energy_ready_i (energy_ready_i),
        .best_energy_o  (best_energy_o),
        .best_spin_o    (best_spin_o),
        .best_update_o  (best_update_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    function automatic logic [31:0] rand32();
        logic [31:0] x;
        x = rng_q;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_q = x;
        return x;
    endfunction

    // E = sum_i s_i * sum_j J(i,j) * s_j + hscaling * sum_i h_i * s_i
    function automatic energy_t model_energy(spin_t s);
        int e;
        int row_sum;
        int hsum;
        int w;
        int scl;
        e    = 0;
        hsum = 0;
        scl  = hscaling_i;
        for (int i = 0; i < NUM_SPIN; i++) begin
            row_sum = 0;
            for (int j = 0; j < NUM_SPIN; j++) begin
                w = $signed(mem_q[i / PARALLELISM][(i % PARALLELISM) * J_ROW_BIT + j * BITJ +: BITJ]);
                row_sum = row_sum + (s[j] ? w : -w);
            end
            e = e + (s[i] ? row_sum : -row_sum);
            w = $signed(hbias_i[i * BITH +: BITH]);
            hsum = hsum + (s[i] ? w : -w);
        end
        return energy_t'(e + scl * hsum);
    endfunction

    task automatic abort_run(string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("MISMATCH %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic fill_problem();
        logic [31:0] r;
        for (int a = 0; a < J_ROWS; a++) begin
            for (int k = 0; k < J_WORD_BIT / 32; k++) begin
                mem_q[a][k*32 +: 32] = rand32();
            end
        end
        hbias_i[31:0]  = rand32();
        hbias_i[63:32] = rand32();
        r = rand32();
        hscaling_i = r[SCALING_BIT-1:0];
    endtask

    task automatic check_reset_outputs();
        check_value("energy_valid_o", 32'(energy_valid_o), 32'd0);
        check_value("weight_ren_o", 32'(weight_ren_o), 32'd0);
        check_value("best_update_o", 32'(best_update_o), 32'd0);
        check_value("spin_ready_o", 32'(spin_ready_o), 32'd0);
    endtask

    // one clock cycle, entered at the falling edge
    task automatic run_cycle();
        logic [31:0]    r;
        logic           do_flush;
        energy_result_t exp_res;
        if (read_pend) begin
            weight_rdata_i = mem_q[read_addr];
        end
        check_value("best_update_o", 32'(best_update_o), 32'(expect_update));
        if (best_valid) begin
            check_value("best_energy_o", best_energy_o, best_e);
            check_value("best_spin_o", 32'(best_spin_o), 32'(best_s));
        end
        // output held under back-pressure
        if (hold_prev) begin
            check_value("energy_valid_o", 32'(energy_valid_o), 32'd1);
            check_value("energy_o.energy", energy_o.energy, prev_out.energy);
            check_value("energy_o.spin", 32'(energy_o.spin), 32'(prev_out.spin));
        end
        expect_update = 1'b0;
        hold_prev     = 1'b0;

        r              = rand32();
        do_flush       = (accepted == FLUSH_AT) && !flushed;
        flush_i        = do_flush;
        spin_valid_i   = !do_flush && (accepted < NUM_SPINS_TOTAL) && (r[1:0] != 2'b00);
        spin_i         = r[31:16];
        energy_ready_i = !do_flush && (r[3:2] != 2'b00);
        if (do_flush) begin
            fill_problem();
        end

        #1;
        read_pend = weight_ren_o;
        read_addr = weight_raddr_o;
        if (do_flush) begin
            expect_q.delete();
            best_valid  = 1'b0;
            flushed     = 1'b1;
            idle_cycles = 0;
        end else begin
            if (energy_valid_o && expect_q.size() == 0) begin
                abort_run("a result appeared while no spin was pending");
            end
            if (energy_valid_o && energy_ready_i) begin
                exp_res = expect_q.pop_front();
                check_value("energy_o.energy", energy_o.energy, exp_res.energy);
                check_value("energy_o.spin", 32'(energy_o.spin), 32'(exp_res.spin));
                if (!best_valid || exp_res.energy < best_e) begin
                    best_valid    = 1'b1;
                    best_e        = exp_res.energy;
                    best_s        = exp_res.spin;
                    expect_update = 1'b1;
                end
                idle_cycles = 0;
            end else if (energy_valid_o) begin
                hold_prev = 1'b1;
                prev_out  = energy_o;
            end
            if (spin_valid_i && spin_ready_o) begin
                exp_res.energy = model_energy(spin_i);
                exp_res.spin   = spin_i;
                expect_q.push_back(exp_res);
                accepted++;
            end
            if (expect_q.size() != 0) begin
                idle_cycles++;
                if (idle_cycles > RESULT_LIMIT) begin
                    abort_run("timeout: a pending spin produced no result");
                end
            end
        end
    endtask

    initial begin
        rng_q          = 32'h4c8d1494;
        arst_n_i       = 1'b0;
        flush_i        = 1'b0;
        spin_valid_i   = 1'b0;
        spin_i         = '0;
        energy_ready_i = 1'b0;
        weight_rdata_i = '0;
        hbias_i        = '0;
        hscaling_i     = '0;
        fill_problem();
        read_pend      = 1'b0;
        read_addr      = '0;
        best_valid     = 1'b0;
        best_e         = '0;
        best_s         = '0;
        expect_update  = 1'b0;
        hold_prev      = 1'b0;
        prev_out       = '0;
        accepted       = 0;
        cycles         = 0;
        idle_cycles    = 0;
        flushed        = 1'b0;

        repeat (3) begin
            @(negedge clk_i);
            check_reset_outputs();
        end
        arst_n_i = 1'b1;
        #1;
        // units still leaving reset
        check_reset_outputs();

        while (accepted < NUM_SPINS_TOTAL || expect_q.size() != 0) begin
            @(negedge clk_i);
            run_cycle();
            cycles++;
            if (cycles > RUN_LIMIT) begin
                abort_run("timeout: the run did not finish within the cycle limit");
            end
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: weight_fetch.sv
/* Weight memory prefetch buffer */

`timescale 1ns/1ps
`default_nettype none

module weight_fetch
    import ising_pkg::*;
(
    input  wire logic                  clk_i,
    input  wire logic                  arst_n_i,
    input  wire logic                  flush_i,
    output logic                       weight_ren_o,
    output logic [J_ADDR_BIT-1:0]      weight_raddr_o,
    input  wire j_word_t               weight_rdata_i,
    output logic                       word_valid_o,
    output j_word_t                    word_data_o,
    input  wire logic                  word_ready_i
);

    j_word_t                    buf_q [FETCH_DEPTH];
    logic [FETCH_PTR_BIT-1:0]   wptr_q;
    logic [FETCH_PTR_BIT-1:0]   rptr_q;
    logic [FETCH_CNT_BIT-1:0]   count_q;
    logic [J_ADDR_BIT-1:0]      addr_q;
    logic                       inflight_q;
    logic                       alive_q;
    logic                       push;
    logic                       pop;

    // only read when the returning word is sure to find a free slot
    assign weight_ren_o   = alive_q && !flush_i &&
                            ((count_q + FETCH_CNT_BIT'(inflight_q)) <
                             FETCH_CNT_BIT'(FETCH_DEPTH));
    assign weight_raddr_o = addr_q;

    // memory answers one cycle after the read
    assign push         = inflight_q;
    assign word_valid_o = (count_q != '0);
    assign word_data_o  = buf_q[rptr_q];
    assign pop          = word_valid_o && word_ready_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            alive_q    <= 1'b0;
            inflight_q <= 1'b0;
            addr_q     <= '0;
            wptr_q     <= '0;
            rptr_q     <= '0;
            count_q    <= '0;
        end else begin
            alive_q <= 1'b1;
            if (flush_i) begin
                inflight_q <= 1'b0;
                addr_q     <= '0;
                wptr_q     <= '0;
                rptr_q     <= '0;
                count_q    <= '0;
            end else begin
                inflight_q <= weight_ren_o;
                if (weight_ren_o) begin
                    addr_q <= addr_q + 1'b1;
                end
                if (push) begin
                    wptr_q <= wptr_q + 1'b1;
                end
                if (pop) begin
                    rptr_q <= rptr_q + 1'b1;
                end
                count_q <= count_q + FETCH_CNT_BIT'(push) - FETCH_CNT_BIT'(pop);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            buf_q[wptr_q] <= weight_rdata_i;
        end
    end

    a_no_push_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        push |-> (count_q < FETCH_CNT_BIT'(FETCH_DEPTH)));

endmodule

`default_nettype wire
